//--- neuron.f
+incdir+rtl
rtl/neuron_pkg.sv
rtl/fp_mult.sv
rtl/fp_add.sv
rtl/apb_decode.sv
rtl/neuron_execute.sv
rtl/relu_result.sv
rtl/neuron_apb_top.sv
testbench/neuron_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the neuron testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal -f neuron.f --top-module neuron_tb -o neuron_sim
./obj_dir/neuron_sim | tee sim.log

if grep -q "Testbench passed" sim.log; then
	echo "simulation PASS"
else
	echo "simulation FAIL"
	exit 1
fi

//--- testbench/neuron_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "neuron_macros.svh"

module neuron_tb;

	localparam int CLK_PERIOD = 100;
	localparam int TEST_COUNT = 5;
	localparam int CYCLES_PER_TEST = 60;

	logic                          clk;
	logic                          rst;
	logic                          psel;
	logic                          penable;
	logic                          pwrite;
	logic [`NEURON_APB_ADDR_W-1:0] paddr;
	logic [31:0]                   pwdata;
	logic [31:0]                   prdata;
	logic                          pready;
	logic                          pslverr;

	logic [31:0] lcg_state;
	int          error_count;
	int          tests_passed;
	int          tests_failed;
	int          errors_at_start;
	int          term_data [`NEURON_MAX_INPUTS];
	int          term_weight [`NEURON_MAX_INPUTS];

	neuron_apb_top i_neuron_apb_top (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	initial
	begin
		#(TEST_COUNT * CYCLES_PER_TEST * CLK_PERIOD);
		$display("watchdog expired before the tests finished");
		$display("Testbench failed");
		$finish;
	end

	function logic [31:0] int_to_float(input int value);
		logic        sign;
		logic [31:0] mag;
		int          msb;
		if (value == 0)
			return 32'd0;
		sign = value < 0;
		mag = sign ? -value : value;
		msb = 0;
		for (int i = 0; i < 31; i++)
			if (mag[i])
				msb = i;
		return {sign, 8'(127 + msb), 23'(mag << (23 - msb))}; // Hidden bit shifted out
	endfunction

	function int next_small_int();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return int'((lcg_state >> 16) % 17) - 8; // Range -8 to 8
	endfunction

	function logic [31:0] expected_relu(input int n);
		int sum;
		sum = 0;
		for (int i = 0; i < n; i++)
			sum += term_data[i] * term_weight[i];
		return (sum > 0) ? int_to_float(sum) : 32'd0;
	endfunction

	task check_value(input string name, input logic [31:0] expected, input logic [31:0] actual);
		if (expected !== actual)
		begin
			$display("mismatch at %0t: %s expected %h actual %h", $time, name, expected, actual);
			error_count++;
		end
	endtask

	// Called and returns 1 ns after a rising edge
	task apb_access(input logic write, input logic [`NEURON_APB_ADDR_W-1:0] addr,
			input logic [31:0] data, output logic [31:0] rdata, output logic err);
		psel = 1'b1;
		penable = 1'b0;
		pwrite = write;
		paddr = addr;
		pwdata = data;
		@(posedge clk);
		#1 penable = 1'b1;
		@(negedge clk);
		rdata = prdata;
		err = pslverr & pready;
		check_value("pready", 32'd1, 32'(pready));
		@(posedge clk);
		#1 psel = 1'b0;
		penable = 1'b0;
	endtask

	task write_reg(input logic [`NEURON_APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, addr, data, rdata, err);
		check_value("pslverr", 32'd0, 32'(err));
	endtask

	task write_refused(input logic [`NEURON_APB_ADDR_W-1:0] addr, input logic [31:0] data);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b1, addr, data, rdata, err);
		check_value("pslverr", 32'd1, 32'(err));
	endtask

	task read_check(input string name, input logic [`NEURON_APB_ADDR_W-1:0] addr,
			input logic [31:0] expected);
		logic [31:0] rdata;
		logic        err;
		apb_access(1'b0, addr, 32'd0, rdata, err);
		check_value(name, expected, rdata);
		check_value("pslverr", 32'd0, 32'(err));
	endtask

	task wait_done();
		logic [31:0] status;
		logic        err;
		int          polls;
		status = 32'd0;
		polls = 0;
		while (!status[1] && polls < 40)
		begin
			apb_access(1'b0, neuron_pkg::REG_STATUS, 32'd0, status, err);
			polls++;
		end
		if (!status[1])
		begin
			$display("done flag never rose within %0d status polls at %0t", polls, $time);
			error_count++;
		end
	endtask

	task load_terms(input int n);
		for (int i = 0; i < n; i++)
		begin
			write_reg(neuron_pkg::REG_INPUT_BASE + 8'(4 * i), int_to_float(term_data[i]));
			write_reg(neuron_pkg::REG_WEIGHT_BASE + 8'(4 * i), int_to_float(term_weight[i]));
		end
	endtask

	task run_node(input int n);
		write_reg(neuron_pkg::REG_COUNT, 32'(n));
		write_reg(neuron_pkg::REG_CTRL, 32'd1);
		wait_done();
	endtask

	task finish_test(input string name);
		if (error_count == errors_at_start)
		begin
			tests_passed++;
			$display("test %s: ok", name);
		end
		else
		begin
			tests_failed++;
			$display("test %s: %0d errors", name, error_count - errors_at_start);
		end
		errors_at_start = error_count;
	endtask

	task test_readback();
		read_check("status", neuron_pkg::REG_STATUS, 32'd0);
		read_check("result", neuron_pkg::REG_RESULT, 32'd0);
		for (int k = 0; k < 4; k++)
		begin
			write_reg(neuron_pkg::REG_INPUT_BASE + 8'(20 * k), int_to_float(k + 1));
			write_reg(neuron_pkg::REG_WEIGHT_BASE + 8'(20 * k), int_to_float(-3 - k));
		end
		for (int k = 0; k < 4; k++)
		begin
			read_check("input", neuron_pkg::REG_INPUT_BASE + 8'(20 * k), int_to_float(k + 1));
			read_check("weight", neuron_pkg::REG_WEIGHT_BASE + 8'(20 * k), int_to_float(-3 - k));
		end
		write_reg(neuron_pkg::REG_COUNT, 32'd9);
		read_check("count", neuron_pkg::REG_COUNT, 32'd9);
		finish_test("register readback");
	endtask

	task test_dot_four();
		term_data = '{1, -2, 3, 5, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		term_weight = '{2, 3, -1, 4, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0, 0};
		load_terms(4);
		run_node(4);
		read_check("result", neuron_pkg::REG_RESULT, expected_relu(4));
		read_check("status", neuron_pkg::REG_STATUS, 32'd2); // Done and not busy
		finish_test("dot product of four");
	endtask

	task test_relu();
		term_data[0] = 2;
		term_data[1] = 3;
		term_weight[0] = -4;
		term_weight[1] = 1;
		load_terms(2);
		write_reg(neuron_pkg::REG_COUNT, 32'd2);
		write_reg(neuron_pkg::REG_CTRL, 32'd1);
		read_check("status", neuron_pkg::REG_STATUS, 32'd1); // Old done cleared
		wait_done();
		read_check("result", neuron_pkg::REG_RESULT, expected_relu(2));
		term_weight[0] = 4;
		term_weight[1] = -1;
		load_terms(2);
		write_reg(neuron_pkg::REG_CTRL, 32'd1);
		read_check("status", neuron_pkg::REG_STATUS, 32'd1);
		wait_done();
		read_check("result", neuron_pkg::REG_RESULT, expected_relu(2));
		finish_test("relu");
	endtask

	task test_count_limits();
		run_node(0);
		read_check("result", neuron_pkg::REG_RESULT, 32'd0);
		for (int i = 0; i < `NEURON_MAX_INPUTS; i++)
		begin
			term_data[i] = next_small_int();
			term_weight[i] = next_small_int();
		end
		load_terms(`NEURON_MAX_INPUTS);
		run_node(`NEURON_MAX_INPUTS);
		read_check("result", neuron_pkg::REG_RESULT, expected_relu(`NEURON_MAX_INPUTS));
		finish_test("count limits");
	endtask

	task test_errors();
		logic [31:0] rdata;
		logic        err;
		write_refused(8'h10, 32'd5);
		apb_access(1'b0, 8'h10, 32'd0, rdata, err); // Unmapped read
		check_value("pslverr", 32'd1, 32'(err));
		write_refused(neuron_pkg::REG_RESULT, 32'd7);
		write_reg(neuron_pkg::REG_COUNT, 32'(`NEURON_MAX_INPUTS));
		write_reg(neuron_pkg::REG_CTRL, 32'd1);
		write_refused(neuron_pkg::REG_WEIGHT_BASE + 8'd12, int_to_float(term_weight[3] + 1));
		read_check("weight", neuron_pkg::REG_WEIGHT_BASE + 8'd12, int_to_float(term_weight[3]));
		write_refused(neuron_pkg::REG_CTRL, 32'd1);
		wait_done();
		finish_test("errors");
	endtask

	initial
	begin
		clk = 1'b0;
		rst = 1'b1;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		paddr = '0;
		pwdata = 32'd0;
		lcg_state = 32'hebd8_725e;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		errors_at_start = 0;
		repeat (16) @(posedge clk);
		#1 rst = 1'b0;

		test_readback();
		test_dot_four();
		test_relu();
		test_count_limits();
		test_errors();

		$display("tests passed %0d, failed %0d, errors %0d", tests_passed, tests_failed,
			error_count);
		if (error_count == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- rtl/neuron_apb_top.sv
`default_nettype none
`timescale 1ns/100ps

`include "neuron_macros.svh"

module neuron_apb_top (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          psel,
	input  logic                          penable,
	input  logic                          pwrite,
	input  logic [`NEURON_APB_ADDR_W-1:0] paddr,
	input  logic [31:0]                   pwdata,
	output logic [31:0]                   prdata,
	output logic                          pready,
	output logic                          pslverr
);

	neuron_pkg::mac_cmd_t                  cmd;
	logic [$clog2(`NEURON_MAX_INPUTS)-1:0] op_index;
	neuron_pkg::operand_t                  operand;
	neuron_pkg::sum_t                      sum;
	logic                                  busy;
	logic                                  done;
	neuron_pkg::fp32_t                     result;

	apb_decode i_apb_decode (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cmd(cmd),
		.op_index(op_index),
		.operand(operand),
		.busy(busy),
		.done(done),
		.result(result)
	);

	neuron_execute i_neuron_execute (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.op_index(op_index),
		.operand(operand),
		.sum(sum)
	);

	relu_result i_relu_result (
		.clk(clk),
		.rst(rst),
		.cmd(cmd),
		.sum(sum),
		.busy(busy),
		.done(done),
		.result(result)
	);

endmodule

`default_nettype wire

//--- rtl/relu_result.sv
`default_nettype none
`timescale 1ns/100ps

module relu_result (
	input  logic                 clk,
	input  logic                 rst,
	input  neuron_pkg::mac_cmd_t cmd,
	input  neuron_pkg::sum_t     sum,
	output logic                 busy,
	output logic                 done,
	output neuron_pkg::fp32_t    result
);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else if (cmd.start)
		begin
			busy <= 1'b1;
			done <= 1'b0;
		end
		else if (sum.valid)
		begin
			result <= sum.value.sign ? '0 : sum.value; // ReLU clamp
			busy <= 1'b0;
			done <= 1'b1;
		end
	end

endmodule

`default_nettype wire

//--- rtl/neuron_execute.sv
`default_nettype none
`timescale 1ns/100ps

`include "neuron_macros.svh"

module neuron_execute (
	input  logic                                  clk,
	input  logic                                  rst,
	input  neuron_pkg::mac_cmd_t                  cmd,
	output logic [$clog2(`NEURON_MAX_INPUTS)-1:0] op_index,
	input  neuron_pkg::operand_t                  operand,
	output neuron_pkg::sum_t                      sum
);

	localparam int IDX_W = $clog2(`NEURON_MAX_INPUTS);
	localparam int CNT_W = $clog2(`NEURON_MAX_INPUTS + 1);

	logic [IDX_W-1:0]   idx_q;
	logic [CNT_W-1:0]   left_q;
	logic               active_q;
	logic               valid_q;
	neuron_pkg::fp32_t  acc_q;
	neuron_pkg::fp32_t  product;
	neuron_pkg::fp32_t  acc_next;

	fp_mult i_fp_mult (
		.a(operand.data),
		.b(operand.weight),
		.y(product)
	);

	fp_add i_fp_add (
		.a(acc_q),
		.b(product),
		.y(acc_next)
	);

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			idx_q <= '0;
			left_q <= '0;
			active_q <= 1'b0;
			valid_q <= 1'b0;
		end
		else
		begin
			valid_q <= 1'b0;
			if (cmd.start)
			begin
				idx_q <= '0;
				left_q <= cmd.count;
				active_q <= cmd.count != '0;
				valid_q <= cmd.count == '0; // Empty dot product
			end
			else if (active_q)
			begin
				idx_q <= idx_q + 1'b1;
				left_q <= left_q - 1'b1;
				if (left_q == CNT_W'(1))
				begin
					active_q <= 1'b0;
					valid_q <= 1'b1; // Last term taken
				end
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (cmd.start)
			acc_q <= '0;
		else if (active_q)
			acc_q <= acc_next;
	end

	assign op_index = idx_q;
	assign sum.valid = valid_q;
	assign sum.value = acc_q;

endmodule

`default_nettype wire

//--- rtl/apb_decode.sv
`default_nettype none
`timescale 1ns/100ps

`include "neuron_macros.svh"

module apb_decode (
	input  logic                                  clk,
	input  logic                                  rst,
	input  logic                                  psel,
	input  logic                                  penable,
	input  logic                                  pwrite,
	input  logic [`NEURON_APB_ADDR_W-1:0]         paddr,
	input  logic [31:0]                           pwdata,
	output logic [31:0]                           prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	output neuron_pkg::mac_cmd_t                  cmd,
	input  logic [$clog2(`NEURON_MAX_INPUTS)-1:0] op_index,
	output neuron_pkg::operand_t                  operand,
	input  logic                                  busy,
	input  logic                                  done,
	input  neuron_pkg::fp32_t                     result
);

	localparam int IDX_W = $clog2(`NEURON_MAX_INPUTS);
	localparam int CNT_W = $clog2(`NEURON_MAX_INPUTS + 1);
	localparam int REGION_LSB = IDX_W + 2;

	neuron_pkg::fp32_t               input_q [`NEURON_MAX_INPUTS];
	neuron_pkg::fp32_t               weight_q [`NEURON_MAX_INPUTS];
	logic [CNT_W-1:0]                count_q;
	logic                            start_q;
	logic [`NEURON_APB_ADDR_W-1:0]   region;
	logic [IDX_W-1:0]                reg_idx;
	logic                            aligned;
	logic                            access;
	logic                            busy_any;
	logic                            is_ctrl;
	logic                            is_count;
	logic                            is_status;
	logic                            is_result;
	logic                            is_input;
	logic                            is_weight;
	logic                            mapped;
	logic                            wr_ok;

	assign region = {paddr[`NEURON_APB_ADDR_W-1:REGION_LSB], {REGION_LSB{1'b0}}};
	assign reg_idx = paddr[2 +: IDX_W];
	assign aligned = paddr[1:0] == 2'b00;

	assign is_ctrl = paddr == neuron_pkg::REG_CTRL;
	assign is_count = paddr == neuron_pkg::REG_COUNT;
	assign is_status = paddr == neuron_pkg::REG_STATUS;
	assign is_result = paddr == neuron_pkg::REG_RESULT;
	assign is_input = aligned && region == neuron_pkg::REG_INPUT_BASE;
	assign is_weight = aligned && region == neuron_pkg::REG_WEIGHT_BASE;
	assign mapped = is_ctrl | is_count | is_status | is_result | is_input | is_weight;

	assign busy_any = busy | start_q; // Covers the start cycle
	assign access = psel & penable;
	assign pready = 1'b1; // No wait states
	assign pslverr = access & (!mapped | (pwrite & (is_status | is_result | busy_any)));
	assign wr_ok = access & pwrite & !pslverr;

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			count_q <= '0;
			start_q <= 1'b0;
		end
		else
		begin
			start_q <= wr_ok & is_ctrl & pwdata[0];
			if (wr_ok && is_count)
			begin
				if (pwdata > `NEURON_MAX_INPUTS)
					count_q <= CNT_W'(`NEURON_MAX_INPUTS); // Clamp to register count
				else
					count_q <= pwdata[CNT_W-1:0];
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_ok && is_input)
			input_q[reg_idx] <= pwdata;
		if (wr_ok && is_weight)
			weight_q[reg_idx] <= pwdata;
	end

	always_comb
	begin
		prdata = 32'd0; // CTRL and unmapped read zero
		if (is_count)
			prdata = 32'(count_q);
		else if (is_status)
			prdata = {30'd0, done, busy_any};
		else if (is_result)
			prdata = result;
		else if (is_input)
			prdata = input_q[reg_idx];
		else if (is_weight)
			prdata = weight_q[reg_idx];
	end

	assign cmd.start = start_q;
	assign cmd.count = count_q;

	assign operand.data = input_q[op_index];
	assign operand.weight = weight_q[op_index];

endmodule

`default_nettype wire

//--- rtl/fp_add.sv
`default_nettype none
`timescale 1ns/100ps

module fp_add (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t y
);

	neuron_pkg::fp32_t  big;
	neuron_pkg::fp32_t  small_op;
	logic [23:0]        big_m;
	logic [23:0]        small_m;
	logic [23:0]        small_sh;
	logic [7:0]         exp_diff;
	logic [24:0]        raw;
	logic [23:0]        norm;
	logic [4:0]         lz;
	logic               found;
	logic signed [9:0]  exp_out;

	always_comb
	begin
		if ({a.exp, a.mant} >= {b.exp, b.mant})
		begin
			big = a;
			small_op = b;
		end
		else
		begin
			big = b;
			small_op = a;
		end

		// Subnormals count as zero
		big_m = (big.exp != 8'd0) ? {1'b1, big.mant} : 24'd0;
		small_m = (small_op.exp != 8'd0) ? {1'b1, small_op.mant} : 24'd0;

		exp_diff = big.exp - small_op.exp;
		small_sh = (exp_diff > 8'd23) ? 24'd0 : (small_m >> exp_diff); // Align

		if (big.sign == small_op.sign)
		begin
			raw = {1'b0, big_m} + {1'b0, small_sh};
		end
		else
		begin
			raw = {1'b0, big_m} - {1'b0, small_sh}; // Never negative
		end

		lz = 5'd0;
		found = 1'b0;
		for (int i = 23; i >= 0; i--)
		begin
			if (!found && raw[i])
			begin
				found = 1'b1;
			end
			else if (!found)
			begin
				lz = lz + 5'd1;
			end
		end
		norm = raw[23:0] << lz;

		if (raw[24])
		begin
			exp_out = $signed({2'b00, big.exp}) + 10'sd1; // Carry out
			y.mant = raw[23:1];
		end
		else
		begin
			exp_out = $signed({2'b00, big.exp}) - $signed({5'd0, lz});
			y.mant = norm[22:0];
		end
		y.sign = big.sign;
		y.exp = exp_out[7:0];

		if (raw == 25'd0)
		begin
			y = '0; // Exact cancellation gives +0
		end
		else if (exp_out <= 10'sd0)
		begin
			y = {big.sign, 31'd0};
		end
	end

endmodule

`default_nettype wire

//--- rtl/fp_mult.sv
`default_nettype none
`timescale 1ns/100ps

module fp_mult (
	input  neuron_pkg::fp32_t a,
	input  neuron_pkg::fp32_t b,
	output neuron_pkg::fp32_t y
);

	logic               sign;
	logic [47:0]        prod;
	logic signed [9:0]  exp_sum;
	logic [22:0]        mant;

	always_comb
	begin
		sign = a.sign ^ b.sign;
		prod = {1'b1, a.mant} * {1'b1, b.mant}; // Hidden bits restored
		exp_sum = $signed({2'b00, a.exp}) + $signed({2'b00, b.exp}) - 10'sd127;
		if (prod[47])
		begin
			exp_sum = exp_sum + 10'sd1; // Product in [2,4)
			mant = prod[46:24];
		end
		else
		begin
			mant = prod[45:23];
		end

		y.sign = sign;
		y.exp = exp_sum[7:0];
		y.mant = mant; // Truncated

		if (a.exp == 8'd0 || b.exp == 8'd0 || exp_sum <= 10'sd0)
		begin
			y = {sign, 31'd0}; // Flush to signed zero
		end
	end

endmodule

`default_nettype wire

//--- rtl/neuron_pkg.sv
`default_nettype none

`include "neuron_macros.svh"

package neuron_pkg;

	typedef struct packed {
		logic        sign;
		logic [7:0]  exp;
		logic [22:0] mant;
	} fp32_t;

	typedef struct packed {
		logic                                   start;
		logic [$clog2(`NEURON_MAX_INPUTS+1)-1:0] count; // 0 to max terms
	} mac_cmd_t;

	typedef struct packed {
		fp32_t data;
		fp32_t weight;
	} operand_t;

	typedef struct packed {
		logic  valid;
		fp32_t value;
	} sum_t;

	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_CTRL        = 'h00;
	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_COUNT       = 'h04;
	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_STATUS      = 'h08;
	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_RESULT      = 'h0C;
	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_INPUT_BASE  = 'h40;
	localparam logic [`NEURON_APB_ADDR_W-1:0] REG_WEIGHT_BASE = 'h80;

endpackage

`default_nettype wire

//--- rtl/neuron_macros.svh
`ifndef NEURON_MACROS_SVH
`define NEURON_MACROS_SVH

// Number of input and weight registers
`define NEURON_MAX_INPUTS 16

// APB byte address width
`define NEURON_APB_ADDR_W 8

`endif
